// File: hw/cpu_pkg.sv
// shared widths and encodings for the 8-bit core
// decode field positions assume data_width of 8
// mem_op_t keeps read and write on separate bits so the top level can split them
package cpu_pkg;

  localparam int data_width = 8;
  localparam int reg_count = 4; // registers per bank

  typedef enum logic [3:0] {
    fetch,
    decode,
    alu_op,
    ldx_op,
    ldx_wait_ram_read,
    ldx_wait_imm_read,
    ldx_wait_write,
    jmp_wait_param_read,
    inc_pc
  } ctrl_state_t;

  typedef enum logic [1:0] {
    op_sys,
    op_alu,
    op_ldx,
    op_jmp
  } opcode_t;

  typedef enum logic [1:0] {
    ram_to_reg,
    reg_to_ram,
    imm_to_reg
  } ldx_op_t;

  typedef enum logic [1:0] {
    mem_nop = 2'b00,
    mem_read = 2'b01, // bit 0
    mem_write = 2'b10 // bit 1
  } mem_op_t;

  typedef enum logic [2:0] {
    ar_nop,
    ar_inc,
    ar_dec,
    ar_load,
    ar_clear
  } addr_op_t;

  // codes 11..15 give zero, carry clear
  typedef enum logic [3:0] {
    thr,
    add,
    sub,
    and_op,
    or_op,
    xor_op,
    inc,
    dec,
    shl,
    shr,
    not_op
  } alu_op_t;

  typedef enum logic [1:0] {
    mux_alu,
    mux_mem,
    mux_io
  } mux_sel_t;

  typedef enum logic [0:0] {
    sel_pc,
    sel_mar
  } addr_sel_t;

endpackage

// File: hw/alu.sv
// combinational ALU, carry is carry out, borrow, or the bit shifted out
// unused operation codes give zero with carry clear
`timescale 1ns/100ps

module alu import cpu_pkg::*; (
  input logic [data_width-1:0] a,
  input logic [data_width-1:0] b,
  input alu_op_t alu_op,
  output logic [data_width-1:0] result,
  output logic carry,
  output logic zero
);

  logic [data_width:0] wide; // carry in top bit

  always_comb begin
    wide = '0;
    case (alu_op)
      thr: wide = {1'b0, a};
      add: wide = {1'b0, a} + {1'b0, b};
      sub: wide = {1'b0, a} - {1'b0, b}; // top bit is borrow
      and_op: wide = {1'b0, a & b};
      or_op: wide = {1'b0, a | b};
      xor_op: wide = {1'b0, a ^ b};
      inc: wide = {1'b0, a} + 1'b1;
      dec: wide = {1'b0, a} - 1'b1;
      shl: wide = {a, 1'b0};
      shr: wide = {a[0], 1'b0, a[data_width-1:1]};
      not_op: wide = {1'b0, ~a};
      default: wide = '0;
    endcase
  end

  assign result = wide[data_width-1:0];
  assign carry = wide[data_width];
  assign zero = (result == '0);

endmodule

// File: hw/reg_file.sv
// two banks of four registers, one write port and two combinational read ports
// read port 2 is fixed to bank 0
`timescale 1ns/100ps

module reg_file import cpu_pkg::*; (
  input logic clock,
  input logic reset,
  input logic reg_write,
  input logic [1:0] reg_sel_in,
  input logic [1:0] reg_sel_1,
  input logic [1:0] reg_sel_2,
  input logic bank_in,
  input logic bank_out_1,
  input mux_sel_t mux_sel,
  input logic [data_width-1:0] alu_result,
  input logic [data_width-1:0] mem_rdata,
  input logic [data_width-1:0] io_in,
  output logic [data_width-1:0] rd_data_1,
  output logic [data_width-1:0] rd_data_2
);

  logic [data_width-1:0] regs [0:1][0:reg_count-1];
  logic [data_width-1:0] wdata;

  always_comb begin
    case (mux_sel)
      mux_mem: wdata = mem_rdata;
      mux_io: wdata = io_in;
      default: wdata = alu_result;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int bk = 0; bk < 2; bk++)
        for (int r = 0; r < reg_count; r++)
          regs[bk][r] <= '0;
    end else if (reg_write) begin
      regs[bank_in][reg_sel_in] <= wdata;
    end
  end

  assign rd_data_1 = regs[bank_out_1][reg_sel_1];
  assign rd_data_2 = regs[0][reg_sel_2];

endmodule

// File: hw/addr_regs.sv
// PC and MAR, one of them updated per cycle as picked by addr_sel
// the same select drives the memory address
`timescale 1ns/100ps

module addr_regs import cpu_pkg::*; (
  input logic clock,
  input logic reset,
  input addr_op_t addr_op,
  input addr_sel_t addr_sel,
  input logic [data_width-1:0] load_value,
  output logic [data_width-1:0] mem_addr
);

  logic [data_width-1:0] pc;
  logic [data_width-1:0] mar;
  logic [data_width-1:0] next_value;

  assign mem_addr = (addr_sel == sel_mar) ? mar : pc;

  always_comb begin
    case (addr_op)
      ar_inc: next_value = mem_addr + 1'b1;
      ar_dec: next_value = mem_addr - 1'b1;
      ar_load: next_value = load_value;
      ar_clear: next_value = '0;
      default: next_value = mem_addr; // nop and unused codes
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc <= '0;
      mar <= '0;
    end else if (addr_sel == sel_mar) begin
      mar <= next_value;
    end else begin
      pc <= next_value;
    end
  end

endmodule

// File: hw/ctrl.sv
// multi-cycle control unit, every output registered one cycle after the decision
// memory must hold mem_rdata after mem_done until the next request starts,
// since register writes from memory happen in the cycle after mem_done
// a taken or skipped JMP always consumes both instruction bytes
`timescale 1ns/100ps

module ctrl import cpu_pkg::*; (
  input logic clock,
  input logic reset,
  input logic [data_width-1:0] bus_data_in,
  input logic mem_done,
  input logic flag_carry_in,
  input logic flag_zero_in,
  output mem_op_t mem_op,
  output addr_op_t addr_op,
  output addr_sel_t addr_sel,
  output alu_op_t alu_op,
  output logic reg_write,
  output logic [1:0] reg_sel_in,
  output logic [1:0] reg_sel_1,
  output logic [1:0] reg_sel_2,
  output logic bank_in,
  output logic bank_out_1,
  output mux_sel_t mux_sel
);

  ctrl_state_t state;
  ldx_op_t ldx_kind; // pending LDX variant
  addr_sel_t jmp_sel; // JMP target, kept across byte 2 read
  logic flag_carry;
  logic flag_zero;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= fetch;
      mem_op <= mem_nop;
      addr_op <= ar_nop;
      addr_sel <= sel_pc;
      alu_op <= thr;
      reg_write <= 1'b0;
      reg_sel_in <= 2'd0;
      reg_sel_1 <= 2'd0;
      reg_sel_2 <= 2'd0;
      bank_in <= 1'b0;
      bank_out_1 <= 1'b0;
      mux_sel <= mux_alu;
      ldx_kind <= ram_to_reg;
      jmp_sel <= sel_pc;
      flag_carry <= 1'b0;
      flag_zero <= 1'b0;
    end else begin
      mem_op <= mem_nop;
      addr_op <= ar_nop;
      addr_sel <= sel_pc;
      alu_op <= thr;
      reg_write <= 1'b0;
      reg_sel_in <= 2'd0;
      reg_sel_1 <= 2'd0;
      reg_sel_2 <= 2'd0;
      bank_in <= 1'b0;
      bank_out_1 <= 1'b0;
      mux_sel <= mux_alu;

      case (state)
        fetch: begin
          mem_op <= mem_read;
          mux_sel <= mux_mem;
          state <= decode;
        end

        decode: begin
          mem_op <= mem_read; // hold until done
          mux_sel <= mux_mem;
          if (mem_done) begin
            mem_op <= mem_nop;
            case (opcode_t'(bus_data_in[7:6]))
              op_sys: begin
                if (bus_data_in[5]) begin // io read
                  reg_sel_in <= bus_data_in[4:3];
                  bank_in <= bus_data_in[2];
                  mux_sel <= mux_io;
                  reg_write <= 1'b1;
                end
                state <= inc_pc;
              end
              op_alu: begin
                alu_op <= alu_op_t'(bus_data_in[5:2]);
                reg_sel_1 <= bus_data_in[1:0];
                addr_op <= ar_inc; // step to byte 2
                state <= cpu_pkg::alu_op;
              end
              op_ldx: begin
                ldx_kind <= ldx_op_t'(bus_data_in[5:4]);
                reg_sel_in <= bus_data_in[3:2];
                bank_in <= bus_data_in[1];
                reg_sel_1 <= bus_data_in[3:2];
                bank_out_1 <= bus_data_in[1];
                if (ldx_op_t'(bus_data_in[5:4]) == imm_to_reg)
                  addr_op <= ar_inc;
                state <= ldx_op;
              end
              default: begin
                addr_op <= ar_inc; // skip over or read byte 2
                if ((bus_data_in[5] && !flag_carry) || (bus_data_in[4] && !flag_zero)) begin
                  state <= inc_pc;
                end else begin
                  reg_sel_1 <= bus_data_in[3:2];
                  bank_out_1 <= bus_data_in[0];
                  jmp_sel <= addr_sel_t'(bus_data_in[1]);
                  state <= jmp_wait_param_read;
                end
              end
            endcase
          end
        end

        cpu_pkg::alu_op: begin
          mem_op <= mem_read;
          mux_sel <= mux_mem;
          alu_op <= alu_op;
          reg_sel_1 <= reg_sel_1;
          if (mem_done) begin
            mem_op <= mem_nop;
            reg_sel_2 <= bus_data_in[7:6];
            reg_sel_in <= bus_data_in[5:4];
            bank_in <= bus_data_in[3];
            bank_out_1 <= bus_data_in[2];
            mux_sel <= mux_alu;
            reg_write <= 1'b1;
            state <= inc_pc;
          end
        end

        ldx_op: begin
          reg_sel_in <= reg_sel_in;
          bank_in <= bank_in;
          reg_sel_1 <= reg_sel_1;
          bank_out_1 <= bank_out_1;
          case (ldx_kind)
            ram_to_reg: begin
              mem_op <= mem_read;
              addr_sel <= sel_mar;
              mux_sel <= mux_mem;
              state <= ldx_wait_ram_read;
            end
            reg_to_ram: begin
              mem_op <= mem_write;
              addr_sel <= sel_mar;
              state <= ldx_wait_write;
            end
            imm_to_reg: begin
              mem_op <= mem_read; // PC already on the immediate
              mux_sel <= mux_mem;
              state <= ldx_wait_imm_read;
            end
            default: state <= inc_pc;
          endcase
        end

        ldx_wait_ram_read, ldx_wait_imm_read: begin
          mem_op <= mem_read;
          addr_sel <= (state == ldx_wait_ram_read) ? sel_mar : sel_pc;
          mux_sel <= mux_mem;
          reg_sel_in <= reg_sel_in;
          bank_in <= bank_in;
          if (mem_done) begin
            mem_op <= mem_nop; // address kept for the write cycle
            reg_write <= 1'b1;
            state <= inc_pc;
          end
        end

        ldx_wait_write: begin
          mem_op <= mem_write;
          addr_sel <= sel_mar;
          reg_sel_1 <= reg_sel_1;
          bank_out_1 <= bank_out_1;
          if (mem_done) begin
            mem_op <= mem_nop;
            state <= inc_pc;
          end
        end

        jmp_wait_param_read: begin
          mem_op <= mem_read;
          mux_sel <= mux_mem;
          reg_sel_1 <= reg_sel_1; // thr feeds load value
          bank_out_1 <= bank_out_1;
          if (mem_done) begin
            mem_op <= mem_nop;
            addr_sel <= jmp_sel;
            addr_op <= addr_op_t'(bus_data_in[7:5]);
            mux_sel <= mux_alu;
            state <= inc_pc;
          end
        end

        inc_pc: begin
          if (reg_write && mux_sel == mux_alu) begin // ALU result being written
            flag_carry <= flag_carry_in;
            flag_zero <= flag_zero_in;
          end
          addr_op <= ar_inc;
          state <= fetch;
        end

        default: state <= fetch;
      endcase
    end
  end

endmodule

// File: hw/cpu_top.sv
// core top level, memory port uses a held request ended by a one-cycle mem_done
// mem_read and mem_write are never high together
`timescale 1ns/100ps

module cpu_top import cpu_pkg::*; (
  input logic clock,
  input logic reset,
  input logic [data_width-1:0] mem_rdata,
  input logic mem_done,
  input logic [data_width-1:0] io_in,
  output logic [data_width-1:0] mem_addr,
  output logic [data_width-1:0] mem_wdata,
  output logic mem_read,
  output logic mem_write
);

  mem_op_t mem_op;
  addr_op_t addr_op;
  addr_sel_t addr_sel;
  alu_op_t alu_op;
  mux_sel_t mux_sel;
  logic reg_write;
  logic [1:0] reg_sel_in;
  logic [1:0] reg_sel_1;
  logic [1:0] reg_sel_2;
  logic bank_in;
  logic bank_out_1;
  logic [data_width-1:0] rd_data_1;
  logic [data_width-1:0] rd_data_2;
  logic [data_width-1:0] alu_result;
  logic alu_carry;
  logic alu_zero;

  assign mem_read = mem_op[0];
  assign mem_write = mem_op[1];
  assign mem_wdata = alu_result; // stores go through thr

  ctrl ctrl_i (
    .clock(clock),
    .reset(reset),
    .bus_data_in(mem_rdata),
    .mem_done(mem_done),
    .flag_carry_in(alu_carry),
    .flag_zero_in(alu_zero),
    .mem_op(mem_op),
    .addr_op(addr_op),
    .addr_sel(addr_sel),
    .alu_op(alu_op),
    .reg_write(reg_write),
    .reg_sel_in(reg_sel_in),
    .reg_sel_1(reg_sel_1),
    .reg_sel_2(reg_sel_2),
    .bank_in(bank_in),
    .bank_out_1(bank_out_1),
    .mux_sel(mux_sel)
  );

  alu alu_i (
    .a(rd_data_1),
    .b(rd_data_2),
    .alu_op(alu_op),
    .result(alu_result),
    .carry(alu_carry),
    .zero(alu_zero)
  );

  reg_file reg_file_i (
    .clock(clock),
    .reset(reset),
    .reg_write(reg_write),
    .reg_sel_in(reg_sel_in),
    .reg_sel_1(reg_sel_1),
    .reg_sel_2(reg_sel_2),
    .bank_in(bank_in),
    .bank_out_1(bank_out_1),
    .mux_sel(mux_sel),
    .alu_result(alu_result),
    .mem_rdata(mem_rdata),
    .io_in(io_in),
    .rd_data_1(rd_data_1),
    .rd_data_2(rd_data_2)
  );

  addr_regs addr_regs_i (
    .clock(clock),
    .reset(reset),
    .addr_op(addr_op),
    .addr_sel(addr_sel),
    .load_value(alu_result),
    .mem_addr(mem_addr)
  );

endmodule

// File: dv/tb_clock.sv
// 10 ns clock and active-low reset held for the first 5 cycles
// reset is released 1 ns after a rising edge
`timescale 1ns/100ps

module tb_clock (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    reset = 1'b0;
    repeat (5) @(posedge clock);
    #1 reset = 1'b1;
  end

endmodule

// File: dv/cpu_assert.sv
// memory handshake properties, bound into every cpu_top
// fail_count is read by the testbench at the end of the run
`timescale 1ns/100ps

module cpu_assert import cpu_pkg::*; (
  input logic clock,
  input logic reset,
  input logic mem_read,
  input logic mem_write,
  input logic mem_done,
  input logic [data_width-1:0] mem_addr,
  input logic [data_width-1:0] mem_wdata
);

  int fail_count = 0;

  one_request: assert property (@(posedge clock) disable iff (!reset)
    !(mem_read && mem_write))
    else begin
      fail_count++;
      $error("read and write requested in the same cycle");
    end

  held_request: assert property (@(posedge clock) disable iff (!reset)
    (mem_read || mem_write) && !mem_done |=>
      $stable(mem_addr) && $stable(mem_read) && $stable(mem_write))
    else begin
      fail_count++;
      $error("request or address changed before mem_done");
    end

  held_wdata: assert property (@(posedge clock) disable iff (!reset)
    mem_write && !mem_done |=> $stable(mem_wdata))
    else begin
      fail_count++;
      $error("write data changed before mem_done");
    end

  idle_after_reset: assert property (@(posedge clock)
    $rose(reset) |-> !mem_read && !mem_write)
    else begin
      fail_count++;
      $error("memory request active right after reset release");
    end

endmodule

bind cpu_top cpu_assert cpu_assert_i (
  .clock(clock),
  .reset(reset),
  .mem_read(mem_read),
  .mem_write(mem_write),
  .mem_done(mem_done),
  .mem_addr(mem_addr),
  .mem_wdata(mem_wdata)
);

// File: dv/tb_cpu.sv
// testbench for cpu_top with a 256-byte memory of 1 to 4 cycle latency
// program image is built at time 0; results compared per memory access
// run ends after the final self-jump is fetched twice
`timescale 1ns/100ps

module tb_cpu import cpu_pkg::*;;

  logic clock;
  logic reset;
  logic [7:0] mem_rdata;
  logic mem_done;
  logic [7:0] io_in;
  logic [7:0] mem_addr;
  logic [7:0] mem_wdata;
  logic mem_read;
  logic mem_write;

  logic [7:0] mem [0:255];
  logic [7:0] rmem [0:255]; // shadow for the reference
  logic [7:0] rregs [0:1][0:3];
  logic [7:0] rpc;
  logic [7:0] rmar;
  logic rc;
  logic rz;
  int exp_kind[$]; // 0 fetch, 1 read, 2 write
  logic [7:0] exp_addr[$];
  logic [7:0] exp_data[$]; // write data, or io value for a fetch
  logic [15:0] lfsr_state;
  logic [7:0] pc_w;
  logic [7:0] halt_addr;
  int n_instr;
  int limit;
  int cycles = 0;
  int errors = 0;
  int cmp_idx = 0;
  int mem_idx = 0;
  int halt_hits = 0;
  logic timed_out = 1'b0;
  logic busy = 1'b0;
  logic fire;
  int wait_left;
  logic [7:0] req_addr;
  logic [7:0] req_wdata;
  logic req_write;

  tb_clock tb_clock_i (.clock(clock), .reset(reset));

  cpu_top cpu_top_i (
    .clock(clock),
    .reset(reset),
    .mem_rdata(mem_rdata),
    .mem_done(mem_done),
    .io_in(io_in),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_read(mem_read),
    .mem_write(mem_write)
  );

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
  endfunction

  task automatic put_byte(input logic [7:0] b);
    mem[pc_w] = b;
    pc_w = pc_w + 8'd1;
  endtask

  task automatic load_imm(input logic [1:0] r, input logic bk, input logic [7:0] v);
    put_byte({2'b10, 2'd2, r, bk, 1'b0});
    put_byte(v);
  endtask

  task automatic store_reg(input logic [1:0] r, input logic bk);
    put_byte({2'b10, 2'd1, r, bk, 1'b0});
  endtask

  task automatic fetch_ram(input logic [1:0] r, input logic bk);
    put_byte({2'b10, 2'd0, r, bk, 1'b0});
  endtask

  task automatic io_read(input logic [1:0] r, input logic bk);
    put_byte({3'b001, r, bk, 2'b00});
  endtask

  task automatic alu_instr(input logic [3:0] op, input logic [1:0] s1, input logic s1b,
                           input logic [1:0] s2, input logic [1:0] d, input logic db);
    put_byte({2'b01, op, s1});
    put_byte({s2, d, db, s1b, 2'b00});
  endtask

  task automatic jump_instr(input logic need_c, input logic need_z, input logic [1:0] r,
                            input logic to_mar, input logic bk, input addr_op_t aop);
    put_byte({2'b11, need_c, need_z, r, to_mar, bk});
    put_byte({aop, 5'b0});
  endtask

  task automatic build_program();
    for (int i = 0; i < 256; i++)
      mem[i] = 8'(i * 37 + 11); // filler depends on whole address
    pc_w = 8'd0;
    load_imm(0, 0, 8'hC0);
    jump_instr(0, 0, 0, 1, 0, ar_load); // MAR = C0
    load_imm(1, 0, 8'hC5);
    load_imm(2, 0, 8'h3A);
    load_imm(3, 0, 8'hFF);
    for (int op = 0; op < 12; op++) begin
      alu_instr(4'(op), (op % 2) ? 2'd3 : 2'd1, 1'b0, 2'(op % 3), 2'd0, 1'b1);
      store_reg(0, 1);
      jump_instr(0, 0, 0, 1, 0, ar_inc);
    end
    jump_instr(0, 0, 0, 1, 0, ar_dec);
    jump_instr(0, 0, 0, 1, 0, ar_dec);
    fetch_ram(3, 1);
    jump_instr(0, 0, 0, 1, 0, ar_clear);
    fetch_ram(2, 0); // reads a program byte
    load_imm(0, 0, 8'hD0);
    jump_instr(0, 0, 0, 1, 0, ar_load);
    store_reg(3, 1);
    jump_instr(0, 0, 0, 1, 0, ar_inc);
    store_reg(2, 0);
    jump_instr(0, 0, 0, 1, 0, ar_inc);
    io_read(1, 1);
    io_read(2, 0);
    put_byte(8'h00); // plain nop
    store_reg(1, 1);
    jump_instr(0, 0, 0, 1, 0, ar_inc);
    store_reg(2, 0);
    jump_instr(0, 0, 0, 1, 0, ar_inc);
    load_imm(1, 0, 8'h01);
    alu_instr(add, 3, 0, 1, 0, 1); // zero result with carry
    jump_instr(1, 0, 0, 0, 0, ar_inc);
    store_reg(0, 1);
    alu_instr(or_op, 1, 0, 1, 0, 1);
    jump_instr(1, 0, 0, 0, 0, ar_inc);
    store_reg(0, 1);
    jump_instr(0, 1, 0, 0, 0, ar_inc);
    store_reg(0, 1);
    jump_instr(0, 0, 0, 1, 0, ar_inc);
    alu_instr(xor_op, 1, 0, 1, 0, 1);
    jump_instr(0, 1, 0, 0, 0, ar_inc);
    store_reg(0, 1);
    jump_instr(1, 1, 0, 0, 0, ar_inc);
    store_reg(0, 1);
    jump_instr(0, 0, 0, 1, 0, ar_inc);
    load_imm(0, 0, pc_w + 8'd4); // jump over one store
    jump_instr(0, 0, 0, 0, 0, ar_load);
    store_reg(1, 1);
    halt_addr = pc_w + 8'd2;
    load_imm(0, 0, pc_w + 8'd1);
    jump_instr(0, 0, 0, 0, 0, ar_load);
  endtask

  function automatic void expect_access(input int kind, input logic [7:0] addr,
                                        input logic [7:0] data);
    exp_kind.push_back(kind);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endfunction

  function automatic logic [8:0] alu_expect(input logic [3:0] op, input logic [7:0] a,
                                            input logic [7:0] b);
    case (op)
      4'd0: return {1'b0, a};
      4'd1: return {1'b0, a} + {1'b0, b};
      4'd2: return {a < b, 8'(a - b)};
      4'd3: return {1'b0, a & b};
      4'd4: return {1'b0, a | b};
      4'd5: return {1'b0, a ^ b};
      4'd6: return {a == 8'hFF, 8'(a + 8'd1)};
      4'd7: return {a == 8'h00, 8'(a - 8'd1)};
      4'd8: return {a[7], a[6:0], 1'b0};
      4'd9: return {a[0], 1'b0, a[7:1]};
      4'd10: return {1'b0, ~a};
      default: return 9'd0;
    endcase
  endfunction

  function automatic logic [7:0] addr_update(input logic [7:0] cur, input logic [2:0] op,
                                             input logic [7:0] v);
    case (op)
      3'd1: return cur + 8'd1;
      3'd2: return cur - 8'd1;
      3'd3: return v;
      3'd4: return 8'd0;
      default: return cur;
    endcase
  endfunction

  // runs the instruction set on the shadow state, one entry per memory access
  function automatic void run_reference();
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] v;
    logic [8:0] wide;
    logic [7:0] io_cur;
    int hits;
    hits = 0;
    io_cur = 8'd0;
    n_instr = 0;
    while (n_instr < 2000) begin
      b1 = rmem[rpc];
      if (b1[7:5] == 3'b001) begin
        io_cur = 8'(take_bits(8));
        rregs[b1[2]][b1[4:3]] = io_cur;
      end
      expect_access(0, rpc, io_cur);
      n_instr++;
      if (rpc == halt_addr) hits++;
      if (hits == 2) break;
      b2 = rmem[rpc + 8'd1];
      case (b1[7:6])
        2'b00: rpc = rpc + 8'd1;
        2'b01: begin
          expect_access(1, rpc + 8'd1, 8'd0);
          wide = alu_expect(b1[5:2], rregs[b2[2]][b1[1:0]], rregs[0][b2[7:6]]);
          rregs[b2[3]][b2[5:4]] = wide[7:0];
          rc = wide[8];
          rz = (wide[7:0] == 8'd0);
          rpc = rpc + 8'd2;
        end
        2'b10: begin
          case (b1[5:4])
            2'd0: begin
              expect_access(1, rmar, 8'd0);
              rregs[b1[1]][b1[3:2]] = rmem[rmar];
              rpc = rpc + 8'd1;
            end
            2'd1: begin
              expect_access(2, rmar, rregs[b1[1]][b1[3:2]]);
              rmem[rmar] = rregs[b1[1]][b1[3:2]];
              rpc = rpc + 8'd1;
            end
            2'd2: begin
              expect_access(1, rpc + 8'd1, 8'd0);
              rregs[b1[1]][b1[3:2]] = b2;
              rpc = rpc + 8'd2;
            end
            default: rpc = rpc + 8'd1;
          endcase
        end
        default: begin
          if ((b1[5] && !rc) || (b1[4] && !rz)) begin
            rpc = rpc + 8'd2; // skipped
          end else begin
            expect_access(1, rpc + 8'd1, 8'd0);
            v = rregs[b1[0]][b1[3:2]];
            if (b1[1]) begin
              rmar = addr_update(rmar, b2[7:5], v);
              rpc = rpc + 8'd2;
            end else begin
              rpc = addr_update(rpc + 8'd1, b2[7:5], v) + 8'd1;
            end
          end
        end
      endcase
    end
  endfunction

  // memory model, latency 1 to 4 cycles from the LFSR
  always @(posedge clock) begin
    fire = 1'b0;
    if (!reset || mem_done) begin
      busy = 1'b0;
    end else begin
      if (!busy && (mem_read || mem_write)) begin
        busy = 1'b1;
        wait_left = take_bits(2) + 1;
      end
      if (busy) begin
        wait_left--;
        fire = (wait_left == 0);
      end
    end
    req_addr = mem_addr;
    req_write = mem_write;
    req_wdata = mem_wdata;
    #1;
    mem_done = fire;
    if (fire) begin
      if (req_write)
        mem[req_addr] = req_wdata;
      else
        mem_rdata = mem[req_addr];
      if (mem_idx < exp_kind.size() && exp_kind[mem_idx] == 0)
        io_in = exp_data[mem_idx];
      mem_idx++;
    end
  end

  // compares each completed access with the reference sequence
  always @(posedge clock) begin
    if (reset && mem_done && halt_hits < 2) begin
      if (cmp_idx >= exp_kind.size()) begin
        errors++;
        $display("memory access at %0t not in the reference sequence", $time);
      end else begin
        assert (mem_addr == exp_addr[cmp_idx])
          else begin
            errors++;
            $display("ERROR %0t: mem_addr expected %02h got %02h", $time,
                     exp_addr[cmp_idx], mem_addr);
          end
        assert (mem_read == (exp_kind[cmp_idx] != 2))
          else begin
            errors++;
            $display("ERROR %0t: mem_read expected %0d got %0d", $time,
                     exp_kind[cmp_idx] != 2, mem_read);
          end
        assert (mem_write == (exp_kind[cmp_idx] == 2))
          else begin
            errors++;
            $display("ERROR %0t: mem_write expected %0d got %0d", $time,
                     exp_kind[cmp_idx] == 2, mem_write);
          end
        if (exp_kind[cmp_idx] == 2)
          assert (mem_wdata == exp_data[cmp_idx])
            else begin
              errors++;
              $display("ERROR %0t: mem_wdata expected %02h got %02h", $time,
                       exp_data[cmp_idx], mem_wdata);
            end
        if (exp_kind[cmp_idx] == 0 && exp_addr[cmp_idx] == halt_addr)
          halt_hits++;
        cmp_idx++;
      end
    end
  end

  always @(posedge clock) begin
    if (reset) begin
      cycles++;
      if (cycles > limit && !timed_out) begin
        timed_out = 1'b1;
        $display("timeout, final jump not reached within %0d cycles", limit);
      end
    end
  end

  initial begin
    mem_rdata = 8'd0;
    mem_done = 1'b0;
    io_in = 8'd0;
    limit = 1000;
    build_program();
    for (int i = 0; i < 256; i++)
      rmem[i] = mem[i];
    for (int i = 0; i < 8; i++)
      rregs[i / 4][i % 4] = 8'd0;
    rpc = 8'd0;
    rmar = 8'd0;
    rc = 1'b0;
    rz = 1'b0;
    lfsr_state = 16'd33699;
    run_reference();
    limit = 40 * n_instr + 5;
    wait (halt_hits == 2 || timed_out);
    $display("value errors %0d, assertion failures %0d, accesses checked %0d of %0d",
             errors, cpu_top_i.cpu_assert_i.fail_count, cmp_idx, exp_kind.size());
    if (errors == 0 && !timed_out && cpu_top_i.cpu_assert_i.fail_count == 0
        && cmp_idx == exp_kind.size())
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: sim.f
hw/cpu_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/addr_regs.sv
hw/ctrl.sv
hw/cpu_top.sv
dv/tb_clock.sv
dv/cpu_assert.sv
dv/tb_cpu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_cpu \
  --Mdir obj_dir -o sim_cpu
./obj_dir/sim_cpu +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation PASSED" sim.log; then
  exit 0
fi
exit 1
